/* hdl/cnn_ctrl_pkg.sv */
package cnn_ctrl_pkg;

    typedef logic [31:0] reg_word_t;
    typedef logic [4:0]  reg_addr_t;   // Five bits so the 0x10 and 0x14 slots exist
    typedef logic [7:0]  pixel_t;
    typedef logic [11:0] result_t;     // Max response 4 * 255 = 1020

    // Register map, one word per slot
    localparam reg_addr_t ADDR_CONTROL     = 5'h00;  // Write only
    localparam reg_addr_t ADDR_PIXEL       = 5'h04;  // Write only, pixel in [7:0]
    localparam reg_addr_t ADDR_STATUS      = 5'h08;
    localparam reg_addr_t ADDR_FRAME_COUNT = 5'h0C;
    localparam reg_addr_t ADDR_ERROR       = 5'h10;
    localparam reg_addr_t ADDR_RESULT      = 5'h14;

    // Control word bits
    localparam int CTRL_CNN_START      = 0;
    localparam int CTRL_CNN_RESET      = 1;
    localparam int CTRL_PIXEL_VALID    = 2;
    localparam int CTRL_FRAME_START    = 3;
    localparam int CTRL_FRAME_COMPLETE = 4;

    // Status word bits, the rest read zero
    localparam int STAT_CNN_BUSY       = 0;
    localparam int STAT_RESULT_VALID   = 1;
    localparam int STAT_PIXEL_VALID    = 2;
    localparam int STAT_FRAME_START    = 3;
    localparam int STAT_FRAME_COMPLETE = 4;
    localparam int STAT_FRAME_LOADED   = 5;

    // Error codes
    localparam reg_word_t ERROR_NONE          = 32'h0000_0000;
    localparam reg_word_t ERROR_INVALID_START = 32'h0000_0002;

    // Fixed 3-tap kernel, W0 on the oldest pixel
    localparam result_t KERNEL_W0 = 12'd1;
    localparam result_t KERNEL_W1 = 12'd2;
    localparam result_t KERNEL_W2 = 12'd1;

endpackage

/* hdl/sync_pipe.sv */
`timescale 1ns/1ps

module sync_pipe #(
    parameter type data_t = logic,
    parameter int  STAGES = 3        // Two or more
) (
    input  logic  clk,
    input  logic  rst_n,
    input  data_t d,
    output data_t q,
    output data_t q_prev            // Stage feeding q, one sample newer
);

    data_t stage [STAGES];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < STAGES; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= d;
            for (int i = 1; i < STAGES; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign q      = stage[STAGES-1];
    assign q_prev = stage[STAGES-2];

endmodule

/* hdl/cnn_reg_bank.sv */
`timescale 1ns/1ps

module cnn_reg_bank (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wr_en,
    input  logic                   rd_en,
    input  cnn_ctrl_pkg::reg_addr_t addr,
    input  cnn_ctrl_pkg::reg_word_t wdata,
    output cnn_ctrl_pkg::reg_word_t rdata,
    output logic                   rd_valid,
    output cnn_ctrl_pkg::reg_word_t control_word,
    output cnn_ctrl_pkg::reg_word_t pixel_word,
    input  cnn_ctrl_pkg::reg_word_t status_word,
    input  cnn_ctrl_pkg::reg_word_t frame_count,
    input  cnn_ctrl_pkg::reg_word_t error_code,
    input  cnn_ctrl_pkg::result_t   result_value
);

    import cnn_ctrl_pkg::*;

    reg_word_t rd_mux;

    // Writable registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            control_word <= '0;
            pixel_word   <= '0;
        end else if (wr_en) begin
            case (addr)
                ADDR_CONTROL: control_word <= wdata;
                ADDR_PIXEL:   pixel_word   <= {24'b0, wdata[7:0]};  // Only the pixel byte kept
                default: ;
            endcase
        end
    end

    // Read decode, write-only slots return zero
    always_comb begin
        case (addr)
            ADDR_STATUS:      rd_mux = status_word;
            ADDR_FRAME_COUNT: rd_mux = frame_count;
            ADDR_ERROR:       rd_mux = error_code;
            ADDR_RESULT:      rd_mux = {20'b0, result_value};
            default:          rd_mux = '0;
        endcase
    end

    // One-cycle read latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata    <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
            if (rd_en) begin
                rdata <= rd_mux;
            end
        end
    end

endmodule

/* hdl/cnn_control_logic.sv */
`timescale 1ns/1ps

module cnn_control_logic #(
    parameter int SYNC_STAGES = 3
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cnn_ctrl_pkg::reg_word_t control_word,
    input  cnn_ctrl_pkg::reg_word_t pixel_word,
    input  logic                    cnn_busy,
    input  logic                    result_valid,
    input  logic                    frame_loaded,
    output logic                    cnn_start,
    output logic                    cnn_reset,
    output logic                    pixel_valid,
    output logic                    frame_start,
    output logic                    frame_complete,
    output cnn_ctrl_pkg::pixel_t    pixel_data,
    output cnn_ctrl_pkg::reg_word_t status_word,
    output cnn_ctrl_pkg::reg_word_t frame_count,
    output cnn_ctrl_pkg::reg_word_t error_code
);

    import cnn_ctrl_pkg::*;

    reg_word_t ctrl_q, ctrl_prev;
    pixel_t    pix_q;
    logic      res_q, res_prev;

    logic start_edge, reset_edge, pixel_edge;
    logic fstart_edge, fcomplete_edge, result_edge;
    logic start_ok;

    // Isolation of the host words and the core's result flag
    sync_pipe #(.data_t(reg_word_t), .STAGES(SYNC_STAGES)) ctrl_pipe (
        .clk(clk), .rst_n(rst_n), .d(control_word), .q(ctrl_q), .q_prev(ctrl_prev)
    );

    sync_pipe #(.data_t(pixel_t), .STAGES(SYNC_STAGES)) pixel_pipe (
        .clk(clk), .rst_n(rst_n), .d(pixel_word[7:0]), .q(pix_q), .q_prev()
    );

    sync_pipe #(.data_t(logic), .STAGES(SYNC_STAGES)) result_pipe (
        .clk(clk), .rst_n(rst_n), .d(result_valid), .q(res_q), .q_prev(res_prev)
    );

    // 0 to 1 between the older sample q and the newer one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_edge     <= 1'b0;
            reset_edge     <= 1'b0;
            pixel_edge     <= 1'b0;
            fstart_edge    <= 1'b0;
            fcomplete_edge <= 1'b0;
            result_edge    <= 1'b0;
        end else begin
            start_edge     <= ctrl_prev[CTRL_CNN_START]      & ~ctrl_q[CTRL_CNN_START];
            reset_edge     <= ctrl_prev[CTRL_CNN_RESET]      & ~ctrl_q[CTRL_CNN_RESET];
            pixel_edge     <= ctrl_prev[CTRL_PIXEL_VALID]    & ~ctrl_q[CTRL_PIXEL_VALID];
            fstart_edge    <= ctrl_prev[CTRL_FRAME_START]    & ~ctrl_q[CTRL_FRAME_START];
            fcomplete_edge <= ctrl_prev[CTRL_FRAME_COMPLETE] & ~ctrl_q[CTRL_FRAME_COMPLETE];
            result_edge    <= res_prev & ~res_q;
        end
    end

    assign start_ok = ~cnn_busy & frame_loaded;  // Idle core and a complete frame

    // Command pulses, frame counter, error code
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnn_start      <= 1'b0;
            cnn_reset      <= 1'b0;
            pixel_valid    <= 1'b0;
            frame_start    <= 1'b0;
            frame_complete <= 1'b0;
            pixel_data     <= '0;
            frame_count    <= '0;
            error_code     <= ERROR_NONE;
        end else begin
            cnn_start      <= start_edge & start_ok;
            cnn_reset      <= reset_edge;
            pixel_valid    <= pixel_edge;
            frame_start    <= fstart_edge;
            frame_complete <= fcomplete_edge;
            pixel_data     <= pix_q;
            if (result_edge) begin
                frame_count <= frame_count + 32'd1;
            end
            if (reset_edge) begin
                error_code <= ERROR_NONE;
            end else if (start_edge && !start_ok) begin
                error_code <= ERROR_INVALID_START;  // Start dropped
            end
        end
    end

    always_comb begin
        status_word                      = '0;
        status_word[STAT_CNN_BUSY]       = cnn_busy;
        status_word[STAT_RESULT_VALID]   = res_q;
        status_word[STAT_PIXEL_VALID]    = pixel_valid;
        status_word[STAT_FRAME_START]    = frame_start;
        status_word[STAT_FRAME_COMPLETE] = frame_complete;
        status_word[STAT_FRAME_LOADED]   = frame_loaded;
    end

endmodule

/* hdl/frame_buffer.sv */
`timescale 1ns/1ps

module frame_buffer #(
    parameter int FRAME_PIXELS = 16
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            frame_start,
    input  logic                            pixel_valid,
    input  logic                            frame_complete,
    input  cnn_ctrl_pkg::pixel_t            pixel_data,
    input  logic [$clog2(FRAME_PIXELS)-1:0] rd_addr,
    output cnn_ctrl_pkg::pixel_t            rd_pixel,
    output logic                            frame_loaded
);

    import cnn_ctrl_pkg::*;

    localparam int IDX_W = $clog2(FRAME_PIXELS);
    localparam int PTR_W = $clog2(FRAME_PIXELS + 1);  // Must reach FRAME_PIXELS

    pixel_t           mem [FRAME_PIXELS];
    logic [PTR_W-1:0] wr_ptr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            frame_loaded <= 1'b0;
        end else if (frame_start) begin
            wr_ptr       <= '0;
            frame_loaded <= 1'b0;
        end else begin
            if (pixel_valid && wr_ptr < PTR_W'(FRAME_PIXELS)) begin
                wr_ptr <= wr_ptr + 1'b1;   // Stops at the end, extra pixels dropped
            end
            if (frame_complete) begin
                frame_loaded <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!frame_start && pixel_valid && wr_ptr < PTR_W'(FRAME_PIXELS)) begin
            mem[wr_ptr[IDX_W-1:0]] <= pixel_data;
        end
        rd_pixel <= mem[rd_addr];
    end

endmodule

/* hdl/cnn_core.sv */
`timescale 1ns/1ps

module cnn_core #(
    parameter int FRAME_PIXELS = 16
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            cnn_start,
    input  logic                            cnn_reset,
    output logic [$clog2(FRAME_PIXELS)-1:0] rd_addr,
    input  cnn_ctrl_pkg::pixel_t            rd_pixel,
    output logic                            cnn_busy,
    output logic                            result_valid,
    output cnn_ctrl_pkg::result_t           result_value
);

    import cnn_ctrl_pkg::*;

    localparam int IDX_W = $clog2(FRAME_PIXELS);
    localparam int CNT_W = $clog2(FRAME_PIXELS + 2);

    logic [CNT_W-1:0] cnt;       // Edges since start
    pixel_t           tap_a;     // p[i]
    pixel_t           tap_b;     // p[i+1], rd_pixel is p[i+2]
    result_t          conv;
    result_t          max_q;
    logic             win_full;

    assign conv = KERNEL_W0 * result_t'(tap_a)
                + KERNEL_W1 * result_t'(tap_b)
                + KERNEL_W2 * result_t'(rd_pixel);

    // Pixel k lands in rd_pixel on edge k+1, so the first full window is at cnt 3
    assign win_full = (cnt >= CNT_W'(3)) && (cnt <= CNT_W'(FRAME_PIXELS));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt          <= '0;
            rd_addr      <= '0;
            cnn_busy     <= 1'b0;
            result_valid <= 1'b0;
            result_value <= '0;
            max_q        <= '0;
        end else begin
            result_valid <= 1'b0;
            if (cnn_reset) begin
                cnn_busy <= 1'b0;   // Abort, no result
                cnt      <= '0;
            end else if (cnn_start) begin
                cnn_busy <= 1'b1;
                cnt      <= '0;
                rd_addr  <= '0;
                max_q    <= '0;
            end else if (cnn_busy) begin
                cnt <= cnt + 1'b1;
                if (rd_addr != IDX_W'(FRAME_PIXELS - 1)) begin
                    rd_addr <= rd_addr + 1'b1;
                end
                if (win_full && conv > max_q) begin
                    max_q <= conv;
                end
                if (cnt == CNT_W'(FRAME_PIXELS + 1)) begin
                    cnn_busy     <= 1'b0;
                    result_valid <= 1'b1;
                    result_value <= max_q;
                end
            end
        end
    end

    // Window shift register
    always_ff @(posedge clk) begin
        if (cnn_busy) begin
            tap_a <= tap_b;
            tap_b <= rd_pixel;
        end
    end

endmodule

/* hdl/cnn_subsystem_top.sv */
`timescale 1ns/1ps

module cnn_subsystem_top #(
    parameter int FRAME_PIXELS = 16,
    parameter int SYNC_STAGES  = 3
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr_en,
    input  logic                    rd_en,
    input  cnn_ctrl_pkg::reg_addr_t addr,
    input  cnn_ctrl_pkg::reg_word_t wdata,
    output cnn_ctrl_pkg::reg_word_t rdata,
    output logic                    rd_valid,
    output logic                    cnn_done
);

    import cnn_ctrl_pkg::*;

    localparam int IDX_W = $clog2(FRAME_PIXELS);

    reg_word_t control_word, pixel_word;
    reg_word_t status_word, frame_count, error_code;
    result_t   result_value;
    pixel_t    pixel_data, rd_pixel;
    logic      cnn_start, cnn_reset, cnn_busy, result_valid;
    logic      pixel_valid, frame_start, frame_complete, frame_loaded;
    logic [IDX_W-1:0] rd_addr;

    cnn_reg_bank u_reg_bank (
        .clk(clk), .rst_n(rst_n), .wr_en(wr_en), .rd_en(rd_en), .addr(addr),
        .wdata(wdata), .rdata(rdata), .rd_valid(rd_valid),
        .control_word(control_word), .pixel_word(pixel_word),
        .status_word(status_word), .frame_count(frame_count),
        .error_code(error_code), .result_value(result_value)
    );

    cnn_control_logic #(.SYNC_STAGES(SYNC_STAGES)) u_control (
        .clk(clk), .rst_n(rst_n), .control_word(control_word), .pixel_word(pixel_word),
        .cnn_busy(cnn_busy), .result_valid(result_valid), .frame_loaded(frame_loaded),
        .cnn_start(cnn_start), .cnn_reset(cnn_reset), .pixel_valid(pixel_valid),
        .frame_start(frame_start), .frame_complete(frame_complete),
        .pixel_data(pixel_data), .status_word(status_word),
        .frame_count(frame_count), .error_code(error_code)
    );

    frame_buffer #(.FRAME_PIXELS(FRAME_PIXELS)) u_frame_buffer (
        .clk(clk), .rst_n(rst_n), .frame_start(frame_start), .pixel_valid(pixel_valid),
        .frame_complete(frame_complete), .pixel_data(pixel_data), .rd_addr(rd_addr),
        .rd_pixel(rd_pixel), .frame_loaded(frame_loaded)
    );

    cnn_core #(.FRAME_PIXELS(FRAME_PIXELS)) u_core (
        .clk(clk), .rst_n(rst_n), .cnn_start(cnn_start), .cnn_reset(cnn_reset),
        .rd_addr(rd_addr), .rd_pixel(rd_pixel), .cnn_busy(cnn_busy),
        .result_valid(result_valid), .result_value(result_value)
    );

    assign cnn_done = result_valid;  // Host completion pulse

endmodule

/* tests/cnn_ctrl_asserts.sv */
`timescale 1ns/1ps

module cnn_ctrl_asserts (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    cnn_start,
    input logic                    cnn_reset,
    input logic                    pixel_valid,
    input logic                    frame_start,
    input logic                    frame_complete,
    input logic                    cnn_busy,
    input cnn_ctrl_pkg::reg_word_t frame_count
);

    int         fail_count = 0;
    logic [4:0] pulses;

    assign pulses = {cnn_start, cnn_reset, pixel_valid, frame_start, frame_complete};

    // No command pulse stays high for two cycles
    a_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        (pulses & $past(pulses)) == '0)
    else begin
        $error("command pulse longer than one cycle");
        fail_count++;
    end

    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cnn_start) |-> !cnn_busy)
    else begin
        $error("cnn_start raised while the core is busy");
        fail_count++;
    end

    a_count_step: assert property (@(posedge clk) disable iff (!rst_n)
        frame_count != $past(frame_count) |-> frame_count == $past(frame_count) + 32'd1)
    else begin
        $error("frame_count moved by more than one");
        fail_count++;
    end

endmodule

bind cnn_control_logic cnn_ctrl_asserts cnn_ctrl_asserts_inst (
    .clk(clk), .rst_n(rst_n), .cnn_start(cnn_start), .cnn_reset(cnn_reset),
    .pixel_valid(pixel_valid), .frame_start(frame_start),
    .frame_complete(frame_complete), .cnn_busy(cnn_busy), .frame_count(frame_count)
);

/* tests/cnn_subsystem_tb.sv */
`timescale 1ns/1ps

module cnn_subsystem_tb;

    import cnn_ctrl_pkg::*;

    localparam int        FRAME_PIXELS = 16;
    localparam int        TIMEOUT      = 200;   // Cycles for one wait
    localparam int        POLL_READS   = 40;
    localparam reg_word_t BUSY_MASK    = reg_word_t'(1) << STAT_CNN_BUSY;
    localparam reg_word_t LOADED_MASK  = reg_word_t'(1) << STAT_FRAME_LOADED;

    logic        clk, rst_n, wr_en, rd_en, rd_valid, cnn_done;
    reg_addr_t   addr;
    reg_word_t   wdata, rdata;
    pixel_t      frame_pix [FRAME_PIXELS];     // Last frame sent, model input
    logic [15:0] lfsr = 16'd15102;
    int          done_count = 0;
    int          error_count = 0;
    int          failed_tests = 0;
    int          frames_done = 0;

    cnn_subsystem_top #(.FRAME_PIXELS(FRAME_PIXELS), .SYNC_STAGES(3)) cnn_subsystem_top_inst (
        .clk(clk), .rst_n(rst_n), .wr_en(wr_en), .rd_en(rd_en), .addr(addr),
        .wdata(wdata), .rdata(rdata), .rd_valid(rd_valid), .cnn_done(cnn_done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(negedge clk) begin
        if (cnn_done) begin
            done_count++;   // Seen mid-cycle, pulse is stable here
        end
    end

    // Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic pixel_t random_pixel();
        pixel_t p = '0;
        for (int i = 0; i < 8; i++) begin
            p    = {p[6:0], lfsr[15]};
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
        return p;
    endfunction

    // Best 3-tap response over every full window of the frame
    function automatic result_t model_max();
        int best = 0;
        int resp;
        for (int i = 0; i + 2 < FRAME_PIXELS; i++) begin
            resp = KERNEL_W0 * frame_pix[i] + KERNEL_W1 * frame_pix[i+1]
                 + KERNEL_W2 * frame_pix[i+2];
            if (resp > best) begin
                best = resp;
            end
        end
        return result_t'(best);
    endfunction

    task automatic check_reg(input string name, input reg_word_t got, input reg_word_t exp);
        if (got !== exp) begin
            $display("Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_result(input string name, input result_t got, input result_t exp);
        if (got !== exp) begin
            $display("Error: %s = 0x%03h, expected 0x%03h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        error_count++;
    endtask

    task automatic reg_write(input reg_addr_t a, input reg_word_t d);
        @(posedge clk);
        wr_en <= 1'b1;
        addr  <= a;
        wdata <= d;
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic reg_read(input reg_addr_t a, output reg_word_t d);
        int cycles = 0;
        @(posedge clk);
        rd_en <= 1'b1;
        addr  <= a;
        @(posedge clk);
        rd_en <= 1'b0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!rd_valid && cycles < TIMEOUT);
        if (!rd_valid) begin
            report_failure("Register read got no rd_valid before the timeout");
        end
        d = rdata;
    endtask

    // Bit written high then low, the control logic fires on the rise
    task automatic send_command(input int bit_idx);
        reg_write(ADDR_CONTROL, reg_word_t'(1) << bit_idx);
        reg_write(ADDR_CONTROL, '0);
    endtask

    // Reads again until the masked value matches or the reads run out
    task automatic read_expect(input reg_addr_t a, input reg_word_t mask, input reg_word_t want,
                               input string name, input int max_reads);
        reg_word_t v;
        int reads = 0;
        do begin
            reg_read(a, v);
            reads++;
        end while ((v & mask) !== want && reads < max_reads);
        check_reg(name, v & mask, want);
    endtask

    task automatic load_frame(input bit mark_complete);
        send_command(CTRL_FRAME_START);
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            frame_pix[i] = random_pixel();
            reg_write(ADDR_PIXEL, reg_word_t'(frame_pix[i]));
            send_command(CTRL_PIXEL_VALID);
        end
        if (mark_complete) begin
            send_command(CTRL_FRAME_COMPLETE);
        end
    endtask

    task automatic wait_done(input int target, output bit seen);
        int cycles = 0;
        while (done_count < target && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        seen = (done_count >= target);
    endtask

    // Result and frame count once a valid run ends
    task automatic finish_run(input int target);
        reg_word_t v;
        bit seen;
        wait_done(target, seen);
        if (!seen) begin
            report_failure("No cnn_done came after a valid start");
        end
        reg_read(ADDR_RESULT, v);
        check_result("result_value", v[11:0], model_max());
        frames_done++;
        read_expect(ADDR_FRAME_COUNT, '1, reg_word_t'(frames_done), "frame_count", POLL_READS);
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        int errs = error_count - errs_before;
        if (errs != 0) begin
            failed_tests++;
        end
        $display("test %0d %-24s %0d errors", num, name, errs);
    endtask

    initial begin
        int  mark;
        int  target;
        int  total;
        bit  seen;
        rst_n = 1'b0;
        wr_en = 1'b0;
        rd_en = 1'b0;
        addr  = '0;
        wdata = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        mark = error_count;
        read_expect(ADDR_STATUS, '1, '0, "status_word", 1);
        read_expect(ADDR_FRAME_COUNT, '1, '0, "frame_count", 1);
        read_expect(ADDR_ERROR, '1, ERROR_NONE, "error_code", 1);
        read_expect(ADDR_RESULT, '1, '0, "result_value", 1);
        report_test(1, "reset values", mark);

        mark = error_count;
        load_frame(1'b1);
        target = done_count + 1;
        send_command(CTRL_CNN_START);
        finish_run(target);
        report_test(2, "single frame", mark);

        mark = error_count;
        repeat (3) begin
            load_frame(1'b1);
            target = done_count + 1;
            send_command(CTRL_CNN_START);
            finish_run(target);
        end
        read_expect(ADDR_FRAME_COUNT, '1, 32'd4, "frame_count", 1);
        report_test(3, "back to back frames", mark);

        // Start with no frame complete, then a start on a busy core
        mark = error_count;
        load_frame(1'b0);
        target = done_count + 1;
        send_command(CTRL_CNN_START);
        read_expect(ADDR_ERROR, '1, ERROR_INVALID_START, "error_code", POLL_READS);
        wait_done(target, seen);
        if (seen) begin
            report_failure("cnn_done came after a start that should have been dropped");
        end
        read_expect(ADDR_FRAME_COUNT, '1, reg_word_t'(frames_done), "frame_count", 1);
        send_command(CTRL_CNN_RESET);
        read_expect(ADDR_ERROR, '1, ERROR_NONE, "error_code", POLL_READS);
        send_command(CTRL_FRAME_COMPLETE);
        target = done_count + 1;
        send_command(CTRL_CNN_START);
        read_expect(ADDR_STATUS, BUSY_MASK, BUSY_MASK, "status.cnn_busy", POLL_READS);
        send_command(CTRL_CNN_START);
        read_expect(ADDR_ERROR, '1, ERROR_INVALID_START, "error_code", POLL_READS);
        finish_run(target);
        report_test(4, "invalid starts", mark);

        mark = error_count;
        load_frame(1'b1);
        target = done_count + 1;
        send_command(CTRL_CNN_START);
        read_expect(ADDR_STATUS, BUSY_MASK, BUSY_MASK, "status.cnn_busy", POLL_READS);
        send_command(CTRL_CNN_RESET);
        wait_done(target, seen);
        if (seen) begin
            report_failure("cnn_done came although the run was reset");
        end
        read_expect(ADDR_FRAME_COUNT, '1, reg_word_t'(frames_done), "frame_count", 1);
        read_expect(ADDR_ERROR, '1, ERROR_NONE, "error_code", 1);
        read_expect(ADDR_STATUS, BUSY_MASK, '0, "status.cnn_busy", 1);
        report_test(5, "reset during run", mark);

        mark = error_count;
        load_frame(1'b1);
        read_expect(ADDR_STATUS, LOADED_MASK, LOADED_MASK, "status.frame_loaded", POLL_READS);
        send_command(CTRL_FRAME_START);
        read_expect(ADDR_STATUS, LOADED_MASK, '0, "status.frame_loaded", POLL_READS);
        report_test(6, "frame loaded flag", mark);

        total = error_count + cnn_subsystem_top_inst.u_control.cnn_ctrl_asserts_inst.fail_count;
        $display("6 tests, %0d failing, %0d errors, %0d assertion failures", failed_tests,
                 error_count, total - error_count);
        if (total == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* cnn_subsystem.f */
hdl/cnn_ctrl_pkg.sv
hdl/sync_pipe.sv
hdl/cnn_reg_bank.sv
hdl/cnn_control_logic.sv
hdl/frame_buffer.sv
hdl/cnn_core.sv
hdl/cnn_subsystem_top.sv
tests/cnn_ctrl_asserts.sv
tests/cnn_subsystem_tb.sv
